/* loader_pkg.sv */
/*
 Shared definitions for the content loader: host download indices,
 the download kind, the stream, word, mount and cheat structs, and the
 register map. Modules refer to these by loader_pkg:: scoped names.
*/
package loader_pkg;

	// ==============================
	// Widths and download indices
	// ==============================
	localparam int RAM_ADDR_W = 27;

	localparam logic [7:0] IDX_BIOS   = 8'd0;
	localparam logic [7:0] IDX_EXE    = 8'd1;
	// Only the low six index bits select a CD image
	localparam logic [5:0] IDX_CD     = 6'd2;
	localparam logic [7:0] IDX_SBI    = 8'd250;
	localparam logic [7:0] IDX_CDINFO = 8'd251;
	localparam logic [7:0] IDX_CODE   = 8'd255;

	// Default RAM placement of BIOS and executable images
	localparam logic [RAM_ADDR_W-1:0] BIOS_BASE_RST = 27'd2097152;
	localparam logic [RAM_ADDR_W-1:0] EXE_BASE_RST  = 27'd4194304;

	// ==============================
	// Register map
	// ==============================
	localparam logic [1:0] REG_BIOS_BASE = 2'd0;
	localparam logic [1:0] REG_EXE_BASE  = 2'd1;
	localparam logic [1:0] REG_OPTIONS   = 2'd2;
	// Bit of the options register
	localparam int OPT_AUTOSAVE = 0;

	// ==============================
	// Types
	// ==============================
	typedef enum logic [2:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CD,
		DL_CDINFO,
		DL_SBI,
		DL_CODE
	} dl_kind_e;

	typedef struct packed {
		logic                  download;
		logic [7:0]            index;
		logic [RAM_ADDR_W-1:0] addr;
		logic [15:0]           data;
		logic                  wr;
	} host_stream_t;

	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [31:0]           data;
	} ram_word_t;

	// Slot 1 is the CD, slots 2 and 3 are memory cards
	typedef struct packed {
		logic [3:0]  slot;
		logic [31:0] size;
	} mount_evt_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

/* dl_word_assembler.sv */
/*
 Classifies the host download by index and pairs its 16-bit writes into
 32-bit words. RAM-bound words go out with a ram_req pulse while the host
 is held off; track-info words go to the track-info port.
*/
`timescale 1ns/100ps

module dl_word_assembler (
	input  logic                              clk_1x,
	input  logic                              arst_n,
	input  loader_pkg::host_stream_t          stream,
	input  logic [loader_pkg::RAM_ADDR_W-1:0] bios_base,
	input  logic [loader_pkg::RAM_ADDR_W-1:0] exe_base,
	input  logic                              ram_done,
	output logic                              ram_req,
	output loader_pkg::ram_word_t             ram_word,
	output logic [8:0]                        trackinfo_addr,
	output logic [31:0]                       trackinfo_data,
	output logic                              trackinfo_wr,
	output logic                              host_wait,
	output loader_pkg::dl_kind_e              dl_kind
);

	loader_pkg::ram_word_t word_q;
	logic                  word_dl;
	logic                  lo_write;
	logic                  hi_write;
	logic [loader_pkg::RAM_ADDR_W-1:0] base;

	function automatic loader_pkg::dl_kind_e kind_of(input logic [7:0] index);
		if (index == loader_pkg::IDX_BIOS)
			return loader_pkg::DL_BIOS;
		if (index == loader_pkg::IDX_EXE)
			return loader_pkg::DL_EXE;
		if (index[5:0] == loader_pkg::IDX_CD)
			return loader_pkg::DL_CD;
		if (index == loader_pkg::IDX_CDINFO)
			return loader_pkg::DL_CDINFO;
		if (index == loader_pkg::IDX_SBI)
			return loader_pkg::DL_SBI;
		if (index == loader_pkg::IDX_CODE)
			return loader_pkg::DL_CODE;
		return loader_pkg::DL_NONE;
	endfunction

	// Kinds that are assembled into words
	assign word_dl = dl_kind inside {loader_pkg::DL_BIOS, loader_pkg::DL_EXE,
		loader_pkg::DL_CD, loader_pkg::DL_CDINFO};
	assign lo_write = word_dl & stream.wr & ~stream.addr[1];
	assign hi_write = word_dl & stream.wr & stream.addr[1];

	// CD and track info are placed at their file address
	always_comb begin
		case (dl_kind)
			loader_pkg::DL_BIOS: base = bios_base;
			loader_pkg::DL_EXE:  base = exe_base;
			default:             base = '0;
		endcase
	end

	// ==============================
	// Control
	// ==============================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_kind      <= loader_pkg::DL_NONE;
			ram_req      <= 1'b0;
			trackinfo_wr <= 1'b0;
			host_wait    <= 1'b0;
		end else begin
			dl_kind      <= stream.download ? kind_of(stream.index) : loader_pkg::DL_NONE;
			ram_req      <= 1'b0;
			trackinfo_wr <= 1'b0;
			if (word_dl) begin
				if (hi_write && dl_kind == loader_pkg::DL_CDINFO) begin
					trackinfo_wr <= 1'b1;
				end else if (hi_write) begin
					ram_req   <= 1'b1;
					host_wait <= 1'b1;
				end
				if (ram_done)
					host_wait <= 1'b0;
			end else begin
				host_wait <= 1'b0;
			end
		end
	end

	// Word payload, low half carries the address
	always_ff @(posedge clk_1x) begin
		if (lo_write) begin
			word_q.addr       <= stream.addr + base;
			word_q.data[15:0] <= stream.data;
		end
		if (hi_write)
			word_q.data[31:16] <= stream.data;
	end

	assign ram_word       = word_q;
	assign trackinfo_addr = word_q.addr[10:2];
	assign trackinfo_data = word_q.data;

endmodule

/* wb_ram_master.sv */
/*
 Wishbone classic write master for assembled download words.
 Each ram_req starts one write that is held until ack; completion is
 reported with a single-cycle ram_done.
*/
`timescale 1ns/100ps

module wb_ram_master (
	input  logic                              clk_1x,
	input  logic                              arst_n,
	input  logic                              ram_req,
	input  loader_pkg::ram_word_t             ram_word,
	output logic                              ram_done,
	output logic                              wb_cyc,
	output logic                              wb_stb,
	output logic                              wb_we,
	output logic [loader_pkg::RAM_ADDR_W-1:0] wb_adr,
	output logic [31:0]                       wb_dat_w,
	output logic [3:0]                        wb_sel,
	input  logic                              wb_ack
);

	logic busy;

	// One write in flight, dropped on the ack edge
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			ram_done <= 1'b0;
		end else begin
			ram_done <= busy & wb_ack;
			if (busy && wb_ack)
				busy <= 1'b0;
			else if (ram_req)
				busy <= 1'b1;
		end
	end

	// Address and data stay put until ack
	always_ff @(posedge clk_1x) begin
		if (ram_req && !busy) begin
			wb_adr   <= ram_word.addr;
			wb_dat_w <= ram_word.data;
		end
	end

	assign wb_cyc = busy;
	assign wb_stb = busy;
	// Write only, full words
	assign wb_we  = 1'b1;
	assign wb_sel = 4'hf;

endmodule

/* cheat_code_loader.sv */
/*
 Builds 128-bit cheat codes from the cheat download. Each record is
 16 bytes, lower half-word first; a complete record raises code_valid.
 cheat_clear marks the start of a new cheat list.
*/
`timescale 1ns/100ps

module cheat_code_loader (
	input  logic                     clk_1x,
	input  logic                     arst_n,
	input  loader_pkg::host_stream_t stream,
	input  loader_pkg::dl_kind_e     dl_kind,
	output logic                     cheat_clear,
	output logic                     code_valid,
	output loader_pkg::cheat_code_t  code
);

	logic code_dl;
	logic code_dl_q;
	logic code_wr;

	assign code_dl = (dl_kind == loader_pkg::DL_CODE);
	assign code_wr = code_dl & stream.wr;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			code_dl_q   <= 1'b0;
			cheat_clear <= 1'b0;
			code_valid  <= 1'b0;
		end else begin
			code_dl_q   <= code_dl;
			cheat_clear <= code_dl & ~code_dl_q;
			// Last half-word of the record
			code_valid  <= code_wr & (stream.addr[3:0] == 4'd14);
		end
	end

	// ==============================
	// Field placement
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (code_wr) begin
			case (stream.addr[3:0])
				4'd0:    code.flags[15:0]    <= stream.data;
				4'd2:    code.flags[31:16]   <= stream.data;
				4'd4:    code.addr[15:0]     <= stream.data;
				4'd6:    code.addr[31:16]    <= stream.data;
				4'd8:    code.compare[15:0]  <= stream.data;
				4'd10:   code.compare[31:16] <= stream.data;
				4'd12:   code.replace[15:0]  <= stream.data;
				4'd14:   code.replace[31:16] <= stream.data;
				default: ;
			endcase
		end
	end

endmodule

/* media_tracker.sv */
/*
 Media status for the console core: CD presence and size, memory-card
 mount state, the copy-protection key, and single-cycle card load and
 save requests from mount events and the menu.
*/
`timescale 1ns/100ps

module media_tracker #(
	parameter int NUM_CARDS = 2
) (
	input  logic                     clk_1x,
	input  logic                     arst_n,
	input  loader_pkg::host_stream_t stream,
	input  loader_pkg::dl_kind_e     dl_kind,
	input  loader_pkg::mount_evt_t   mount,
	input  logic                     autosave_en,
	input  logic                     menu_load,
	input  logic                     menu_save,
	input  logic                     osd_status,
	output logic                     has_cd,
	output logic                     new_cd,
	output logic                     cd_from_sd,
	output logic [29:0]              cd_size,
	output logic [15:0]              libcrypt_key,
	output logic [NUM_CARDS-1:0]     card_mounted,
	output logic [NUM_CARDS-1:0]     card_load,
	output logic                     card_save
);

	logic cd_dl;
	logic cd_dl_q;
	logic size_nz;
	logic save_auto;
	logic menu_load_q;
	logic menu_save_q;
	logic save_auto_q;

	assign cd_dl     = (dl_kind == loader_pkg::DL_CD);
	assign size_nz   = |mount.size;
	assign save_auto = osd_status & autosave_en;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			cd_dl_q      <= 1'b0;
			has_cd       <= 1'b0;
			new_cd       <= 1'b0;
			cd_from_sd   <= 1'b0;
			cd_size      <= '0;
			card_mounted <= '0;
			card_load    <= '0;
			card_save    <= 1'b0;
			menu_load_q  <= 1'b0;
			menu_save_q  <= 1'b0;
			save_auto_q  <= 1'b0;
		end else begin
			cd_dl_q     <= cd_dl;
			new_cd      <= 1'b0;
			card_load   <= '0;
			menu_load_q <= menu_load;
			menu_save_q <= menu_save;
			save_auto_q <= save_auto;

			// CD loaded into RAM, its size is the last address
			if (cd_dl_q && !cd_dl) begin
				cd_size    <= 30'(stream.addr);
				has_cd     <= 1'b1;
				cd_from_sd <= 1'b0;
			end

			// A mounted image overrides the RAM copy
			if (mount.slot[1]) begin
				if (size_nz) begin
					cd_size    <= mount.size[29:0];
					has_cd     <= 1'b1;
					cd_from_sd <= 1'b1;
					new_cd     <= 1'b1;
				end else begin
					has_cd <= 1'b0;
				end
			end

			// ==============================
			// Memory cards
			// ==============================
			for (int i = 0; i < NUM_CARDS; i++) begin
				if (mount.slot[i + 2]) begin
					card_mounted[i] <= size_nz;
					card_load[i]    <= size_nz;
				end
			end
			if (menu_load && !menu_load_q)
				card_load <= '1;
			card_save <= (menu_save & ~menu_save_q) | (save_auto & ~save_auto_q);
		end
	end

	// Key from the sbi download
	always_ff @(posedge clk_1x) begin
		if (dl_kind == loader_pkg::DL_SBI && stream.wr)
			libcrypt_key <= stream.data;
	end

endmodule

/* loader_regs.sv */
/*
 Wishbone classic register block of the loader: BIOS base, executable
 base and the options word. Acks one cycle after a strobe and waits for
 the strobe to drop before the next access.
*/
`timescale 1ns/100ps

module loader_regs (
	input  logic                              clk_1x,
	input  logic                              arst_n,
	input  logic                              wb_cyc,
	input  logic                              wb_stb,
	input  logic                              wb_we,
	input  logic [1:0]                        wb_adr,
	input  logic [31:0]                       wb_dat_w,
	output logic [31:0]                       wb_dat_r,
	output logic                              wb_ack,
	output logic [loader_pkg::RAM_ADDR_W-1:0] bios_base,
	output logic [loader_pkg::RAM_ADDR_W-1:0] exe_base,
	output logic                              autosave_en
);

	logic [31:0] options;
	logic [31:0] rd_data;
	logic        served;

	// Unmapped words read as zero
	always_comb begin
		case (wb_adr)
			loader_pkg::REG_BIOS_BASE: rd_data = 32'(bios_base);
			loader_pkg::REG_EXE_BASE:  rd_data = 32'(exe_base);
			loader_pkg::REG_OPTIONS:   rd_data = options;
			default:                   rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack    <= 1'b0;
			wb_dat_r  <= '0;
			served    <= 1'b0;
			bios_base <= loader_pkg::BIOS_BASE_RST;
			exe_base  <= loader_pkg::EXE_BASE_RST;
			options   <= '0;
		end else begin
			wb_ack <= 1'b0;
			if (!wb_stb) begin
				served <= 1'b0;
			end else if (wb_cyc && !served) begin
				served <= 1'b1;
				wb_ack <= 1'b1;
				if (wb_we) begin
					case (wb_adr)
						loader_pkg::REG_BIOS_BASE:
							bios_base <= wb_dat_w[loader_pkg::RAM_ADDR_W-1:0];
						loader_pkg::REG_EXE_BASE:
							exe_base <= wb_dat_w[loader_pkg::RAM_ADDR_W-1:0];
						loader_pkg::REG_OPTIONS:
							options <= wb_dat_w;
						default: ;
					endcase
				end else begin
					wb_dat_r <= rd_data;
				end
			end
		end
	end

	assign autosave_en = options[loader_pkg::OPT_AUTOSAVE];

endmodule

/* content_loader.sv */
/*
 Top level of the content loader. Connects the download word assembler,
 the RAM write master, the cheat loader, the media tracker and the
 register block. NUM_CARDS sets the number of memory-card slots.
*/
`timescale 1ns/100ps

module content_loader #(
	parameter int NUM_CARDS = 2
) (
	input  logic                              clk_1x,
	input  logic                              arst_n,
	// Host download
	input  loader_pkg::host_stream_t          stream,
	output logic                              host_wait,
	// Register bus
	input  logic                              cfg_cyc,
	input  logic                              cfg_stb,
	input  logic                              cfg_we,
	input  logic [1:0]                        cfg_adr,
	input  logic [31:0]                       cfg_dat_w,
	output logic [31:0]                       cfg_dat_r,
	output logic                              cfg_ack,
	// RAM bus
	output logic                              ram_cyc,
	output logic                              ram_stb,
	output logic                              ram_we,
	output logic [loader_pkg::RAM_ADDR_W-1:0] ram_adr,
	output logic [31:0]                       ram_dat_w,
	output logic [3:0]                        ram_sel,
	input  logic                              ram_ack,
	// Track info
	output logic [8:0]                        trackinfo_addr,
	output logic [31:0]                       trackinfo_data,
	output logic                              trackinfo_wr,
	// Cheats
	output logic                              cheat_clear,
	output logic                              code_valid,
	output loader_pkg::cheat_code_t           code,
	// Media
	input  loader_pkg::mount_evt_t            mount,
	input  logic                              menu_load,
	input  logic                              menu_save,
	input  logic                              osd_status,
	output logic                              has_cd,
	output logic                              new_cd,
	output logic                              cd_from_sd,
	output logic [29:0]                       cd_size,
	output logic [15:0]                       libcrypt_key,
	output logic [NUM_CARDS-1:0]              card_mounted,
	output logic [NUM_CARDS-1:0]              card_load,
	output logic                              card_save
);

	logic [loader_pkg::RAM_ADDR_W-1:0] bios_base;
	logic [loader_pkg::RAM_ADDR_W-1:0] exe_base;
	logic                              autosave_en;
	loader_pkg::dl_kind_e              dl_kind;
	loader_pkg::ram_word_t             ram_word;
	logic                              ram_req;
	logic                              ram_done;

	dl_word_assembler dl_word_assembler_inst (
		.clk_1x(clk_1x), .arst_n(arst_n), .stream(stream),
		.bios_base(bios_base), .exe_base(exe_base),
		.ram_done(ram_done), .ram_req(ram_req), .ram_word(ram_word),
		.trackinfo_addr(trackinfo_addr), .trackinfo_data(trackinfo_data),
		.trackinfo_wr(trackinfo_wr), .host_wait(host_wait), .dl_kind(dl_kind)
	);

	wb_ram_master wb_ram_master_inst (
		.clk_1x(clk_1x), .arst_n(arst_n),
		.ram_req(ram_req), .ram_word(ram_word), .ram_done(ram_done),
		.wb_cyc(ram_cyc), .wb_stb(ram_stb), .wb_we(ram_we), .wb_adr(ram_adr),
		.wb_dat_w(ram_dat_w), .wb_sel(ram_sel), .wb_ack(ram_ack)
	);

	cheat_code_loader cheat_code_loader_inst (
		.clk_1x(clk_1x), .arst_n(arst_n), .stream(stream), .dl_kind(dl_kind),
		.cheat_clear(cheat_clear), .code_valid(code_valid), .code(code)
	);

	media_tracker #(.NUM_CARDS(NUM_CARDS)) media_tracker_inst (
		.clk_1x(clk_1x), .arst_n(arst_n), .stream(stream), .dl_kind(dl_kind),
		.mount(mount), .autosave_en(autosave_en),
		.menu_load(menu_load), .menu_save(menu_save), .osd_status(osd_status),
		.has_cd(has_cd), .new_cd(new_cd), .cd_from_sd(cd_from_sd),
		.cd_size(cd_size), .libcrypt_key(libcrypt_key),
		.card_mounted(card_mounted), .card_load(card_load), .card_save(card_save)
	);

	loader_regs loader_regs_inst (
		.clk_1x(clk_1x), .arst_n(arst_n),
		.wb_cyc(cfg_cyc), .wb_stb(cfg_stb), .wb_we(cfg_we), .wb_adr(cfg_adr),
		.wb_dat_w(cfg_dat_w), .wb_dat_r(cfg_dat_r), .wb_ack(cfg_ack),
		.bios_base(bios_base), .exe_base(exe_base), .autosave_en(autosave_en)
	);

endmodule

/* loader_props.sv */
/*
 Protocol assertions on the RAM bus of the loader, bound into every
 wb_ram_master instance of the testbench.
*/
`timescale 1ns/100ps

module loader_props (
	input logic                              clk_1x,
	input logic                              arst_n,
	input logic                              ram_req,
	input logic                              ram_done,
	input logic                              wb_stb,
	input logic [loader_pkg::RAM_ADDR_W-1:0] wb_adr,
	input logic [31:0]                       wb_dat_w,
	input logic                              wb_ack
);

	// Request held until ack
	hold_until_ack: assert property (@(posedge clk_1x) disable iff (!arst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w))
		else $error("RAM bus request changed before ack");

	drop_on_ack: assert property (@(posedge clk_1x) disable iff (!arst_n)
		wb_stb && wb_ack |=> !wb_stb)
		else $error("RAM bus strobe stayed high after ack");

	single_outstanding: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ram_req |-> !wb_stb)
		else $error("RAM request arrived while a write was in flight");

	done_is_pulse: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ram_done |=> !ram_done)
		else $error("ram_done lasted more than one cycle");

endmodule

bind wb_ram_master loader_props loader_props_inst (
	.clk_1x(clk_1x),
	.arst_n(arst_n),
	.ram_req(ram_req),
	.ram_done(ram_done),
	.wb_stb(wb_stb),
	.wb_adr(wb_adr),
	.wb_dat_w(wb_dat_w),
	.wb_ack(wb_ack)
);

/* tb_loader.sv */
/*
 Testbench for the content loader. Streams a table of host downloads
 through the DUT against a Wishbone RAM model with random ack delay,
 then checks registers, RAM contents, track info, cheats and media status.
*/
`timescale 1ns/100ps

module tb_loader;

	localparam int AW       = loader_pkg::RAM_ADDR_W;
	localparam int TIMEOUT  = 200;
	localparam int NUM_ROWS = 6;
	localparam logic [2:0] T_RAM   = 3'd0;
	localparam logic [2:0] T_CD    = 3'd1;
	localparam logic [2:0] T_TRACK = 3'd2;
	localparam logic [2:0] T_CHEAT = 3'd3;
	localparam logic [2:0] T_SBI   = 3'd4;
	localparam logic [AW-1:0] BIOS_BASE = 27'h0100000;
	localparam logic [AW-1:0] EXE_BASE  = 27'h0340000;

	typedef struct packed {
		logic [7:0]    index;
		logic [7:0]    words;
		logic [15:0]   seed;
		logic [AW-1:0] base;
		logic [2:0]    target;
	} row_t;

	// ==============================
	// Stimulus table
	// ==============================
	// Index 8'h42 only matches the CD index in its low six bits
	row_t rows [NUM_ROWS] = '{
		'{8'd0,   8'd16, 16'h1000, BIOS_BASE, T_RAM},
		'{8'd1,   8'd12, 16'h2400, EXE_BASE,  T_RAM},
		'{8'h42,  8'd10, 16'h3000, 27'd0,     T_CD},
		'{8'd251, 8'd6,  16'h4000, 27'd0,     T_TRACK},
		'{8'd255, 8'd8,  16'h5000, 27'd0,     T_CHEAT},
		'{8'd250, 8'd1,  16'h6000, 27'd0,     T_SBI}
	};
	string names [NUM_ROWS] = '{"bios", "exe", "cd", "cdinfo", "cheat", "sbi"};

	logic                     clk_1x;
	logic                     arst_n;
	loader_pkg::host_stream_t stream;
	logic                     host_wait;
	logic                     cfg_cyc;
	logic                     cfg_stb;
	logic                     cfg_we;
	logic [1:0]               cfg_adr;
	logic [31:0]              cfg_dat_w;
	logic [31:0]              cfg_dat_r;
	logic                     cfg_ack;
	logic                     ram_cyc;
	logic                     ram_stb;
	logic                     ram_we;
	logic [AW-1:0]            ram_adr;
	logic [31:0]              ram_dat_w;
	logic [3:0]               ram_sel;
	logic                     ram_ack;
	logic [8:0]               trackinfo_addr;
	logic [31:0]              trackinfo_data;
	logic                     trackinfo_wr;
	logic                     cheat_clear;
	logic                     code_valid;
	loader_pkg::cheat_code_t  code;
	loader_pkg::mount_evt_t   mount;
	logic                     menu_load;
	logic                     menu_save;
	logic                     osd_status;
	logic                     has_cd;
	logic                     new_cd;
	logic                     cd_from_sd;
	logic [29:0]              cd_size;
	logic [15:0]              libcrypt_key;
	logic [1:0]               card_mounted;
	logic [1:0]               card_load;
	logic                     card_save;

	// Bookkeeping of the RAM model and the output monitor
	int                      seed = 69;
	int                      errors;
	int                      failures;
	logic [31:0]             ram_mem [int];
	int                      ram_writes;
	int                      ram_repeats;
	logic [40:0]             track_q [$];
	loader_pkg::cheat_code_t code_q [$];
	int                      clear_cnt;
	int                      codes_at_clear;
	int                      wait_cnt;
	int                      new_cd_cnt;
	int                      load_cnt;
	logic [1:0]              load_seen;
	int                      save_cnt;

	content_loader content_loader_inst (.*);

	initial begin
		clk_1x = 1'b0;
		forever #2 clk_1x = ~clk_1x;
	end

	// RAM slave, acks 0 to 3 cycles after the strobe
	initial begin
		int delay;
		ram_ack = 1'b0;
		forever begin
			@(posedge clk_1x);
			#1;
			if (ram_stb) begin
				if (ram_cyc !== 1'b1 || ram_we !== 1'b1 || ram_sel !== 4'hf)
					report_mismatch("ram bus cyc we sel", 128'(6'b11_1111),
						128'({ram_cyc, ram_we, ram_sel}));
				delay = {$random(seed)} % 4;
				repeat (delay) begin
					@(posedge clk_1x);
					#1;
				end
				if (ram_mem.exists(int'(ram_adr)))
					ram_repeats++;
				ram_mem[int'(ram_adr)] = ram_dat_w;
				ram_writes++;
				ram_ack = 1'b1;
				@(posedge clk_1x);
				#1;
				ram_ack = 1'b0;
			end
		end
	end

	// Pulse monitor, all sampled outputs are registered
	initial begin
		forever begin
			@(posedge clk_1x);
			#1;
			if (trackinfo_wr)
				track_q.push_back({trackinfo_addr, trackinfo_data});
			if (cheat_clear) begin
				clear_cnt++;
				codes_at_clear = code_q.size();
			end
			if (code_valid)
				code_q.push_back(code);
			if (host_wait)
				wait_cnt++;
			if (new_cd)
				new_cd_cnt++;
			if (card_load != 2'b00) begin
				load_cnt++;
				load_seen = card_load;
			end
			if (card_save)
				save_cnt++;
		end
	end

	task automatic report_mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		errors++;
		$display("error %s expected %0h actual %0h", name, exp, act);
	endtask

	task automatic report_failure(input string msg);
		failures++;
		$display("%s", msg);
	endtask

	task automatic next_cycles(input int n);
		repeat (n) begin
			@(posedge clk_1x);
			#1;
		end
	endtask

	// Test word, high half over low half
	function automatic logic [31:0] word_value(input logic [15:0] start, input int w);
		logic [15:0] lo;
		lo = start + 16'(2 * w);
		return {lo + 16'd1, lo};
	endfunction

	task automatic register_access(input logic we, input logic [1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		cfg_cyc   = 1'b1;
		cfg_stb   = 1'b1;
		cfg_we    = we;
		cfg_adr   = adr;
		cfg_dat_w = wdata;
		n = 0;
		while (!cfg_ack && n < TIMEOUT) begin
			@(posedge clk_1x);
			#1;
			n++;
		end
		if (!cfg_ack)
			report_failure("register bus never acknowledged the access");
		rdata   = cfg_dat_r;
		cfg_cyc = 1'b0;
		cfg_stb = 1'b0;
		cfg_we  = 1'b0;
		next_cycles(1);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (host_wait && n < TIMEOUT) begin
			@(posedge clk_1x);
			#1;
			n++;
		end
		if (host_wait)
			report_failure("host_wait stayed high, RAM write never completed");
	endtask

	task automatic write_half(input logic [AW-1:0] addr, input logic [15:0] data);
		wait_ready();
		stream.addr = addr;
		stream.data = data;
		stream.wr   = 1'b1;
		next_cycles(1);
		stream.wr   = 1'b0;
	endtask

	task automatic stream_row(input row_t r);
		logic [31:0] value;
		stream.index    = r.index;
		stream.download = 1'b1;
		next_cycles(1);
		for (int w = 0; w < int'(r.words); w++) begin
			value = word_value(r.seed, w);
			write_half(AW'(4 * w), value[15:0]);
			write_half(AW'(4 * w + 2), value[31:16]);
		end
		wait_ready();
		// Address is held so the CD size can be taken from it
		stream.download = 1'b0;
		next_cycles(4);
	endtask

	// ==============================
	// Per-row checks
	// ==============================
	task automatic check_row(input int i);
		row_t                    r;
		int                      exp_writes;
		logic [31:0]             value;
		logic [AW-1:0]           a;
		loader_pkg::cheat_code_t exp_code;
		r = rows[i];
		exp_writes = (r.target == T_RAM || r.target == T_CD) ? int'(r.words) : 0;
		if (ram_writes != exp_writes)
			report_mismatch($sformatf("%s ram writes", names[i]), 128'(exp_writes),
				128'(ram_writes));
		if (ram_repeats != 0)
			report_mismatch($sformatf("%s repeated writes", names[i]), 128'(0),
				128'(ram_repeats));
		for (int w = 0; w < int'(r.words); w++) begin
			value = word_value(r.seed, w);
			a = r.base + AW'(4 * w);
			if ((r.target == T_RAM || r.target == T_CD) && !ram_mem.exists(int'(a)))
				report_failure($sformatf("%s word %0d never written to RAM", names[i], w));
			else if ((r.target == T_RAM || r.target == T_CD) && ram_mem[int'(a)] !== value)
				report_mismatch($sformatf("%s ram word %0d", names[i], w), 128'(value),
					128'(ram_mem[int'(a)]));
			if (r.target == T_TRACK && w < track_q.size() && track_q[w] !== {9'(w), value})
				report_mismatch($sformatf("%s track word %0d", names[i], w),
					128'({9'(w), value}), 128'(track_q[w]));
		end
		if (r.target == T_TRACK && track_q.size() != int'(r.words))
			report_mismatch("cdinfo track writes", 128'(r.words), 128'(track_q.size()));
		if (r.target == T_TRACK && wait_cnt != 0)
			report_mismatch("cdinfo host_wait cycles", 128'(0), 128'(wait_cnt));
		if (r.target == T_CHEAT) begin
			if (clear_cnt != 1 || codes_at_clear != 0)
				report_failure("cheat_clear missing or not ahead of the first code");
			if (code_q.size() != int'(r.words) / 4)
				report_mismatch("cheat code count", 128'(int'(r.words) / 4),
					128'(code_q.size()));
			for (int c = 0; c < code_q.size(); c++) begin
				exp_code.flags   = word_value(r.seed, 4 * c);
				exp_code.addr    = word_value(r.seed, 4 * c + 1);
				exp_code.compare = word_value(r.seed, 4 * c + 2);
				exp_code.replace = word_value(r.seed, 4 * c + 3);
				if (code_q[c] !== exp_code)
					report_mismatch($sformatf("cheat code %0d", c), exp_code, code_q[c]);
			end
		end
		if (r.target == T_CD) begin
			if (cd_size !== 30'(4 * (int'(r.words) - 1) + 2))
				report_mismatch("cd download size", 128'(4 * (int'(r.words) - 1) + 2),
					128'(cd_size));
			if (has_cd !== 1'b1 || cd_from_sd !== 1'b0)
				report_mismatch("cd download flags", 128'(2'b10), 128'({has_cd, cd_from_sd}));
		end
		value = word_value(r.seed, int'(r.words) - 1);
		if (r.target == T_SBI && libcrypt_key !== value[31:16])
			report_mismatch("sbi key", 128'(value[31:16]), 128'(libcrypt_key));
	endtask

	initial begin
		logic [31:0] rd;
		arst_n     = 1'b0;
		stream     = '0;
		cfg_cyc    = 1'b0;
		cfg_stb    = 1'b0;
		cfg_we     = 1'b0;
		cfg_adr    = 2'd0;
		cfg_dat_w  = 32'd0;
		mount      = '0;
		menu_load  = 1'b0;
		menu_save  = 1'b0;
		osd_status = 1'b0;
		errors     = 0;
		failures   = 0;
		repeat (5) @(posedge clk_1x);
		#1;
		arst_n = 1'b1;
		next_cycles(1);

		// Register block, reset bases at 2 MiB and 4 MiB
		register_access(1'b0, loader_pkg::REG_BIOS_BASE, 32'd0, rd);
		if (rd !== 32'd2097152)
			report_mismatch("bios base reset", 128'(32'd2097152), 128'(rd));
		register_access(1'b0, loader_pkg::REG_EXE_BASE, 32'd0, rd);
		if (rd !== 32'd4194304)
			report_mismatch("exe base reset", 128'(32'd4194304), 128'(rd));
		register_access(1'b1, loader_pkg::REG_BIOS_BASE, 32'(BIOS_BASE), rd);
		register_access(1'b1, loader_pkg::REG_EXE_BASE, 32'(EXE_BASE), rd);
		register_access(1'b1, loader_pkg::REG_OPTIONS, 32'h0000_5a00, rd);
		register_access(1'b0, loader_pkg::REG_BIOS_BASE, 32'd0, rd);
		if (rd !== 32'(BIOS_BASE))
			report_mismatch("bios base readback", 128'(BIOS_BASE), 128'(rd));
		register_access(1'b0, loader_pkg::REG_EXE_BASE, 32'd0, rd);
		if (rd !== 32'(EXE_BASE))
			report_mismatch("exe base readback", 128'(EXE_BASE), 128'(rd));
		register_access(1'b0, loader_pkg::REG_OPTIONS, 32'd0, rd);
		if (rd !== 32'h0000_5a00)
			report_mismatch("options readback", 128'(32'h0000_5a00), 128'(rd));

		// Download table
		for (int i = 0; i < NUM_ROWS; i++) begin
			ram_mem.delete();
			track_q.delete();
			code_q.delete();
			ram_writes  = 0;
			ram_repeats = 0;
			clear_cnt   = 0;
			wait_cnt    = 0;
			stream_row(rows[i]);
			check_row(i);
		end

		// Media events
		new_cd_cnt  = 0;
		mount.slot  = 4'b0010;
		mount.size  = 32'd1234567;
		next_cycles(1);
		mount = '0;
		next_cycles(2);
		if (has_cd !== 1'b1 || cd_from_sd !== 1'b1)
			report_mismatch("cd mount flags", 128'(2'b11), 128'({has_cd, cd_from_sd}));
		if (cd_size !== 30'd1234567)
			report_mismatch("cd mount size", 128'(30'd1234567), 128'(cd_size));
		if (new_cd_cnt != 1)
			report_mismatch("cd mount new_cd pulses", 128'(1), 128'(new_cd_cnt));
		mount.slot = 4'b0010;
		next_cycles(1);
		mount = '0;
		next_cycles(2);
		if (has_cd !== 1'b0)
			report_mismatch("cd unmount has_cd", 128'(0), 128'(has_cd));
		load_cnt   = 0;
		mount.slot = 4'b0100;
		mount.size = 32'd131072;
		next_cycles(1);
		mount = '0;
		next_cycles(2);
		if (card_mounted !== 2'b01)
			report_mismatch("card mount mounted", 128'(2'b01), 128'(card_mounted));
		if (load_cnt != 1)
			report_mismatch("card mount load pulses", 128'(1), 128'(load_cnt));
		if (load_seen !== 2'b01)
			report_mismatch("card mount load slot", 128'(2'b01), 128'(load_seen));
		load_cnt  = 0;
		menu_load = 1'b1;
		next_cycles(1);
		menu_load = 1'b0;
		next_cycles(2);
		if (load_cnt != 1)
			report_mismatch("menu load pulses", 128'(1), 128'(load_cnt));
		if (load_seen !== 2'b11)
			report_mismatch("menu load cards", 128'(2'b11), 128'(load_seen));
		save_cnt  = 0;
		menu_save = 1'b1;
		next_cycles(1);
		menu_save = 1'b0;
		next_cycles(2);
		if (save_cnt != 1)
			report_mismatch("menu save pulses", 128'(1), 128'(save_cnt));
		// Autosave still off here
		save_cnt   = 0;
		osd_status = 1'b1;
		next_cycles(1);
		osd_status = 1'b0;
		next_cycles(2);
		if (save_cnt != 0)
			report_mismatch("osd save without autosave", 128'(0), 128'(save_cnt));
		register_access(1'b1, loader_pkg::REG_OPTIONS, 32'h0000_0001, rd);
		save_cnt   = 0;
		osd_status = 1'b1;
		next_cycles(1);
		osd_status = 1'b0;
		next_cycles(2);
		if (save_cnt != 1)
			report_mismatch("autosave pulses", 128'(1), 128'(save_cnt));

		$display("errors %0d, other failures %0d", errors, failures);
		if (errors == 0 && failures == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* sources.f */
loader_pkg.sv
dl_word_assembler.sv
wb_ram_master.sv
cheat_code_loader.sv
media_tracker.sv
loader_regs.sv
content_loader.sv
loader_props.sv
tb_loader.sv

/* Makefile */
# Verilator build and run of the content loader testbench
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_loader: sources.f $(SRCS)
	verilator --binary --assert --top-module tb_loader -f sources.f

run: obj_dir/Vtb_loader
	./obj_dir/Vtb_loader > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Everything OK" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
